// ==== stream_combiner_pkg.sv ====
/*
 * Stream combiner shared definitions
 * Default widths and frame length used by the framing stages, the arbiter
 * and the top level of the two-channel sample combiner.
 */

package stream_combiner_pkg;

    // Width of one signed sample on either input channel
    parameter int sample_width = 16;

    // Width of the merged output word
    parameter int word_width = 32;

    // Destination tag carried with every beat
    parameter int dest_width = 8;

    // Side-band user field, passed through untouched
    parameter int user_width = 8;

    // Accepted beats per frame on each channel.
    // The last beat of every frame carries the last flag
    parameter int frame_length = 1024;

    // Nonzero places the destination tag in the top byte of the output word,
    // with the sign fill between the tag and the sample
    parameter int dest_in_msb = 1;

endpackage

// ==== stream_framer.sv ====
/*
 * Stream framer
 * One-entry register stage for a single sample channel. It sign-extends the
 * sample to the output width, optionally places the tag in the top bits,
 * and marks the last beat of every frame by counting accepted beats.
 */

`timescale 1ns/1ps

module stream_framer import stream_combiner_pkg::*; #(
    parameter int sample_w   = sample_width,
    parameter int word_w     = word_width,
    parameter int dest_w     = dest_width,
    parameter int user_w     = user_width,
    parameter int frame_len  = frame_length,
    parameter int tag_in_msb = dest_in_msb
) (
    input  logic              clock,
    input  logic              reset,
    input  logic [sample_w-1:0] in_data,
    input  logic [dest_w-1:0] in_dest,
    input  logic [user_w-1:0] in_user,
    input  logic              in_valid,
    output logic              in_ready,
    output logic [word_w-1:0] out_data,
    output logic [dest_w-1:0] out_dest,
    output logic [user_w-1:0] out_user,
    output logic              out_last,
    output logic              out_valid,
    input  logic              out_ready
);

    // A frame of one beat still needs a one-bit counter
    localparam int count_w = (frame_len > 1) ? $clog2(frame_len) : 1;
    localparam logic [count_w-1:0] last_count = count_w'(frame_len - 1);

    logic [sample_w-1:0] sample_q;
    logic [dest_w-1:0]   dest_q;
    logic [user_w-1:0]   user_q;
    logic                last_q;
    logic                valid_q;
    logic [count_w-1:0]  beat_count;
    logic                accept;
    logic                sign_bit;

    // The stage can take a new beat when it is empty or being drained now,
    // so a steady stream passes at one beat per cycle
    assign in_ready = ~valid_q | out_ready;
    assign accept   = in_valid & in_ready;

    // Valid and the frame counter are the only control state
    always_ff @(posedge clock) begin
        if (!reset) begin
            valid_q    <= 1'b0;
            beat_count <= '0;
            last_q     <= 1'b0;
        end else begin
            if (accept) begin
                valid_q <= 1'b1;
                // Counting acceptances keeps frames exact while valid stays high
                if (beat_count == last_count) begin
                    beat_count <= '0;
                    last_q     <= 1'b1;
                end else begin
                    beat_count <= beat_count + 1'b1;
                    last_q     <= 1'b0;
                end
            end else if (out_ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Payload registers only load on an accepted beat
    always_ff @(posedge clock) begin
        if (accept) begin
            sample_q <= in_data;
            dest_q   <= in_dest;
            user_q   <= in_user;
        end
    end

    assign sign_bit = sample_q[sample_w-1];

    // Word layout is fixed at elaboration
    generate
        if (tag_in_msb != 0) begin : g_tag_msb
            // Tag on top, then the sign fill, then the sample itself
            assign out_data = {dest_q, {(word_w - dest_w - sample_w){sign_bit}}, sample_q};
        end else begin : g_sign_only
            assign out_data = {{(word_w - sample_w){sign_bit}}, sample_q};
        end
    endgenerate

    assign out_dest  = dest_q;
    assign out_user  = user_q;
    assign out_last  = last_q;
    assign out_valid = valid_q;

endmodule

// ==== stream_arbiter.sv ====
/*
 * Stream arbiter
 * Merges two framed streams into one through a single output register.
 * Input a has fixed priority over input b; the last flag travels with
 * its beat, so frame marks survive interleaving.
 */

`timescale 1ns/1ps

module stream_arbiter import stream_combiner_pkg::*; #(
    parameter int word_w = word_width,
    parameter int dest_w = dest_width,
    parameter int user_w = user_width
) (
    input  logic              clock,
    input  logic              reset,

    input  logic [word_w-1:0] a_data,
    input  logic [dest_w-1:0] a_dest,
    input  logic [user_w-1:0] a_user,
    input  logic              a_last,
    input  logic              a_valid,
    output logic              a_ready,

    input  logic [word_w-1:0] b_data,
    input  logic [dest_w-1:0] b_dest,
    input  logic [user_w-1:0] b_user,
    input  logic              b_last,
    input  logic              b_valid,
    output logic              b_ready,

    output logic [word_w-1:0] out_data,
    output logic [dest_w-1:0] out_dest,
    output logic [user_w-1:0] out_user,
    output logic              out_last,
    output logic              out_valid,
    input  logic              out_ready
);

    logic [word_w-1:0] data_q;
    logic [dest_w-1:0] dest_q;
    logic [user_w-1:0] user_q;
    logic              last_q;
    logic              valid_q;

    // Output register may load when empty or when its beat leaves now
    logic              load;
    logic              take_a;
    logic              take_b;

    logic [word_w-1:0] sel_data;
    logic [dest_w-1:0] sel_dest;
    logic [user_w-1:0] sel_user;
    logic              sel_last;

    assign load = ~valid_q | out_ready;

    // Input a wins every tie, b only gets a slot when a is idle
    assign a_ready = load;
    assign b_ready = load & ~a_valid;

    assign take_a = a_valid & a_ready;
    assign take_b = b_valid & b_ready;

    // Select the granted beat for the output register
    always_comb begin
        if (a_valid) begin
            sel_data = a_data;
            sel_dest = a_dest;
            sel_user = a_user;
            sel_last = a_last;
        end else begin
            sel_data = b_data;
            sel_dest = b_dest;
            sel_user = b_user;
            sel_last = b_last;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else if (load) begin
            // Empty slot or drained beat, refill from whichever input was taken
            valid_q <= take_a | take_b;
        end
    end

    // Payload holds under back-pressure and only moves on a transfer
    always_ff @(posedge clock) begin
        if (take_a | take_b) begin
            data_q <= sel_data;
            dest_q <= sel_dest;
            user_q <= sel_user;
            last_q <= sel_last;
        end
    end

    assign out_data  = data_q;
    assign out_dest  = dest_q;
    assign out_user  = user_q;
    assign out_last  = last_q;
    assign out_valid = valid_q;

endmodule

// ==== stream_combiner.sv ====
/*
 * Stream combiner top level
 * Two sample channels, each framed by its own stage, merged by a priority
 * arbiter into one wide output stream. Channel 1 wins any tie.
 */

`timescale 1ns/1ps

module stream_combiner import stream_combiner_pkg::*; #(
    parameter int sample_w   = sample_width,
    parameter int word_w     = word_width,
    parameter int dest_w     = dest_width,
    parameter int user_w     = user_width,
    parameter int frame_len  = frame_length,
    parameter int tag_in_msb = dest_in_msb
) (
    input  logic                clock,
    input  logic                reset,

    input  logic [sample_w-1:0] in_1_data,
    input  logic [dest_w-1:0]   in_1_dest,
    input  logic [user_w-1:0]   in_1_user,
    input  logic                in_1_valid,
    output logic                in_1_ready,

    input  logic [sample_w-1:0] in_2_data,
    input  logic [dest_w-1:0]   in_2_dest,
    input  logic [user_w-1:0]   in_2_user,
    input  logic                in_2_valid,
    output logic                in_2_ready,

    output logic [word_w-1:0]   out_data,
    output logic [dest_w-1:0]   out_dest,
    output logic [user_w-1:0]   out_user,
    output logic                out_last,
    output logic                out_valid,
    input  logic                out_ready
);

    // Framed links into the arbiter
    logic [word_w-1:0] f1_data;
    logic [dest_w-1:0] f1_dest;
    logic [user_w-1:0] f1_user;
    logic              f1_last;
    logic              f1_valid;
    logic              f1_ready;

    logic [word_w-1:0] f2_data;
    logic [dest_w-1:0] f2_dest;
    logic [user_w-1:0] f2_user;
    logic              f2_last;
    logic              f2_valid;
    logic              f2_ready;

    stream_framer #(
        .sample_w   (sample_w),
        .word_w     (word_w),
        .dest_w     (dest_w),
        .user_w     (user_w),
        .frame_len  (frame_len),
        .tag_in_msb (tag_in_msb)
    ) framer_1 (
        .clock     (clock),
        .reset     (reset),
        .in_data   (in_1_data),
        .in_dest   (in_1_dest),
        .in_user   (in_1_user),
        .in_valid  (in_1_valid),
        .in_ready  (in_1_ready),
        .out_data  (f1_data),
        .out_dest  (f1_dest),
        .out_user  (f1_user),
        .out_last  (f1_last),
        .out_valid (f1_valid),
        .out_ready (f1_ready)
    );

    stream_framer #(
        .sample_w   (sample_w),
        .word_w     (word_w),
        .dest_w     (dest_w),
        .user_w     (user_w),
        .frame_len  (frame_len),
        .tag_in_msb (tag_in_msb)
    ) framer_2 (
        .clock     (clock),
        .reset     (reset),
        .in_data   (in_2_data),
        .in_dest   (in_2_dest),
        .in_user   (in_2_user),
        .in_valid  (in_2_valid),
        .in_ready  (in_2_ready),
        .out_data  (f2_data),
        .out_dest  (f2_dest),
        .out_user  (f2_user),
        .out_last  (f2_last),
        .out_valid (f2_valid),
        .out_ready (f2_ready)
    );

    // Channel 1 sits on the priority input
    stream_arbiter #(
        .word_w (word_w),
        .dest_w (dest_w),
        .user_w (user_w)
    ) arbiter (
        .clock     (clock),
        .reset     (reset),
        .a_data    (f1_data),
        .a_dest    (f1_dest),
        .a_user    (f1_user),
        .a_last    (f1_last),
        .a_valid   (f1_valid),
        .a_ready   (f1_ready),
        .b_data    (f2_data),
        .b_dest    (f2_dest),
        .b_user    (f2_user),
        .b_last    (f2_last),
        .b_valid   (f2_valid),
        .b_ready   (f2_ready),
        .out_data  (out_data),
        .out_dest  (out_dest),
        .out_user  (out_user),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// ==== tb_stream_checker.sv ====
/*
 * Stream combiner checker
 * Predicts every output beat from the accepted input beats of both channels,
 * compares it with the DUT output and counts each kind of error.
 */

`timescale 1ns/1ps

module tb_stream_checker import stream_combiner_pkg::*; #(
    parameter int frame_len = frame_length
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [8*16-1:0]         test_name,
    input  logic [sample_width-1:0] in_1_data,
    input  logic [dest_width-1:0]   in_1_dest,
    input  logic [user_width-1:0]   in_1_user,
    input  logic                    in_1_valid,
    input  logic                    in_1_ready,
    input  logic [sample_width-1:0] in_2_data,
    input  logic [dest_width-1:0]   in_2_dest,
    input  logic [user_width-1:0]   in_2_user,
    input  logic                    in_2_valid,
    input  logic                    in_2_ready,
    input  logic [word_width-1:0]   out_data,
    input  logic [dest_width-1:0]   out_dest,
    input  logic [user_width-1:0]   out_user,
    input  logic                    out_last,
    input  logic                    out_valid,
    input  logic                    out_ready,
    output int                      mismatches,
    output int                      unexpected,
    output int                      unstable,
    output int                      pending_1,
    output int                      pending_2
);

    // One beat as {last, user, dest, word}
    localparam int beat_w = 1 + user_width + dest_width + word_width;

    logic [beat_w-1:0] exp_1[$];
    logic [beat_w-1:0] exp_2[$];
    logic [beat_w-1:0] held;
    logic              holding;
    int                beats_1;
    int                beats_2;

    // Sign-extend the sample to the full word, then the tag takes the top byte
    function automatic logic [beat_w-1:0] predict(input logic [sample_width-1:0] sample,
                                                  input logic [dest_width-1:0] dest,
                                                  input logic [user_width-1:0] user,
                                                  input logic last);
        logic [word_width-1:0] word;
        word = {{(word_width - sample_width){sample[sample_width-1]}}, sample};
        word[word_width-1 -: dest_width] = dest;
        return {last, user, dest, word};
    endfunction

    always @(posedge clock) begin
        logic [beat_w-1:0] actual;
        actual = {out_last, out_user, out_dest, out_data};
        if (!reset) begin
            exp_1.delete();
            exp_2.delete();
            beats_1 = 0;
            beats_2 = 0;
            holding = 1'b0;
        end else begin
            // Every frame_len-th accepted beat of a channel closes a frame
            if (in_1_valid && in_1_ready) begin
                exp_1.push_back(predict(in_1_data, in_1_dest, in_1_user,
                                        (beats_1 % frame_len) == frame_len - 1));
                beats_1++;
            end
            if (in_2_valid && in_2_ready) begin
                exp_2.push_back(predict(in_2_data, in_2_dest, in_2_user,
                                        (beats_2 % frame_len) == frame_len - 1));
                beats_2++;
            end
            // A stalled output beat has to stay put until it is taken
            if (holding && (!out_valid || actual != held)) begin
                $display("MISMATCH %s expected %h actual %h while stalled",
                         test_name, held, actual);
                unstable++;
            end
            holding = out_valid && !out_ready;
            held = actual;
            if (out_valid && out_ready) begin
                if (exp_1.size() == 0 && exp_2.size() == 0) begin
                    $display("Output beat %h in %s arrived while no beat was expected",
                             actual, test_name);
                    unexpected++;
                end else if (exp_1.size() != 0 && exp_1[0] == actual) begin
                    void'(exp_1.pop_front());
                end else if (exp_2.size() != 0 && exp_2[0] == actual) begin
                    void'(exp_2.pop_front());
                end else begin
                    $display("MISMATCH %s expected %h actual %h", test_name,
                             (exp_1.size() != 0) ? exp_1[0] : exp_2[0], actual);
                    mismatches++;
                end
            end
        end
        pending_1 = exp_1.size();
        pending_2 = exp_2.size();
    end

endmodule

// ==== tb_stream_combiner.sv ====
/*
 * Stream combiner testbench
 * Applies a stimulus table to both channels and the output ready, drains
 * the DUT and prints the closing summary.
 */

`timescale 1ns/1ps

module tb_stream_combiner import stream_combiner_pkg::*; ();

    localparam int tb_frame_len  = 4;
    localparam int max_rows      = 32;
    localparam int name_w        = 8 * 16;
    localparam int ready_timeout = 50;
    // One channel of a row packs valid, sample, dest and user
    localparam int chan_w        = 1 + sample_width + dest_width + user_width;

    logic                    clock;
    logic                    reset;
    logic [sample_width-1:0] in_1_data;
    logic [dest_width-1:0]   in_1_dest;
    logic [user_width-1:0]   in_1_user;
    logic                    in_1_valid;
    logic                    in_1_ready;
    logic [sample_width-1:0] in_2_data;
    logic [dest_width-1:0]   in_2_dest;
    logic [user_width-1:0]   in_2_user;
    logic                    in_2_valid;
    logic                    in_2_ready;
    logic [word_width-1:0]   out_data;
    logic [dest_width-1:0]   out_dest;
    logic [user_width-1:0]   out_user;
    logic                    out_last;
    logic                    out_valid;
    logic                    out_ready;
    logic [name_w-1:0]       test_name;

    logic [name_w-1:0] row_name  [max_rows];
    logic [chan_w-1:0] row_in_1  [max_rows];
    logic [chan_w-1:0] row_in_2  [max_rows];
    logic              row_ready [max_rows];
    int                row_count;
    int                seed;
    int                timeouts;
    int                leftover;
    int                reset_errors;
    int                mismatches;
    int                unexpected;
    int                unstable;
    int                pending_1;
    int                pending_2;

    stream_combiner #(.frame_len(tb_frame_len), .tag_in_msb(1)) DUT (.*);

    tb_stream_checker #(.frame_len(tb_frame_len)) scoreboard (.*);

    always #50 clock = ~clock;

    function automatic logic [sample_width-1:0] random_sample();
        return sample_width'($random(seed));
    endfunction

    task automatic add_row(input logic [name_w-1:0] name, input logic [chan_w-1:0] chan_1,
                           input logic [chan_w-1:0] chan_2, input logic ready);
        row_name[row_count]  = name;
        row_in_1[row_count]  = chan_1;
        row_in_2[row_count]  = chan_2;
        row_ready[row_count] = ready;
        row_count++;
    endtask

    task automatic build_table();
        logic [sample_width-1:0] sample;
        for (int i = 0; i < 8; i++) begin
            // One fixed positive and one fixed negative sample, then random ones
            sample = (i == 0) ? 16'h1234 : (i == 1) ? 16'hfedc : random_sample();
            add_row("s1_alone", {1'b1, sample, 8'(8'ha0 + i), 8'(8'h10 + i)}, '0, 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            sample = (i == 0) ? 16'h0042 : (i == 1) ? 16'h8000 : random_sample();
            add_row("s2_alone", '0, {1'b1, sample, 8'(8'hb0 + i), 8'(8'h20 + i)}, 1'b1);
        end
        for (int i = 0; i < 6; i++) begin
            add_row("contention", {1'b1, random_sample(), 8'(8'hc0 + i), 8'(8'h30 + i)},
                    {1'b1, random_sample(), 8'(8'hd0 + i), 8'(8'h40 + i)}, 1'b1);
        end
        add_row("settle", '0, '0, 1'b1);
        add_row("settle", '0, '0, 1'b1);
        // Fill the framers and the output register, then stall the output
        add_row("backpressure", {1'b1, random_sample(), 8'he0, 8'h51},
                {1'b1, random_sample(), 8'hf0, 8'h61}, 1'b0);
        add_row("backpressure", {1'b1, random_sample(), 8'he1, 8'h52}, '0, 1'b0);
        add_row("backpressure", '0, '0, 1'b0);
        add_row("backpressure", '0, '0, 1'b0);
        add_row("release", {1'b1, random_sample(), 8'he2, 8'h53},
                {1'b1, random_sample(), 8'hf1, 8'h62}, 1'b1);
    endtask

    // Drive one row and hold each valid beat until the DUT has taken it
    task automatic apply_row(input int r);
        int   wait_cycles;
        logic pend_1;
        logic pend_2;
        logic take_1;
        logic take_2;
        test_name = row_name[r];
        {in_1_valid, in_1_data, in_1_dest, in_1_user} = row_in_1[r];
        {in_2_valid, in_2_data, in_2_dest, in_2_user} = row_in_2[r];
        out_ready = row_ready[r];
        pend_1 = in_1_valid;
        pend_2 = in_2_valid;
        wait_cycles = 0;
        do begin
            #1;
            take_1 = pend_1 & in_1_ready;
            take_2 = pend_2 & in_2_ready;
            @(posedge clock);
            #1;
            if (take_1) begin
                pend_1 = 1'b0;
                in_1_valid = 1'b0;
            end
            if (take_2) begin
                pend_2 = 1'b0;
                in_2_valid = 1'b0;
            end
            wait_cycles++;
        end while ((pend_1 || pend_2) && wait_cycles < ready_timeout);
        if (pend_1 || pend_2) begin
            $display("Timeout in row %0d (%s) waiting for input ready", r, row_name[r]);
            timeouts++;
            in_1_valid = 1'b0;
            in_2_valid = 1'b0;
        end
    endtask

    task automatic check_reset_state();
        if (out_valid !== 1'b0) begin
            $display("MISMATCH %s expected out_valid 0 actual %b", test_name, out_valid);
            reset_errors++;
        end
        if ({in_1_ready, in_2_ready} !== 2'b11) begin
            $display("MISMATCH %s expected input ready 11 actual %b%b", test_name,
                     in_1_ready, in_2_ready);
            reset_errors++;
        end
    endtask

    initial begin
        int total;
        int wait_cycles;
        seed = 63224;
        clock = 1'b0;
        reset = 1'b0;
        {in_1_valid, in_1_data, in_1_dest, in_1_user} = '0;
        {in_2_valid, in_2_data, in_2_dest, in_2_user} = '0;
        out_ready = 1'b0;
        test_name = "reset";
        row_count = 0;
        build_table();
        repeat (3) begin
            @(posedge clock);
            #1;
            check_reset_state();
        end
        reset = 1'b1;
        test_name = "after_reset";
        // The first edge out of reset must not raise any valid by itself
        @(posedge clock);
        #1;
        check_reset_state();
        for (int r = 0; r < row_count; r++) begin
            apply_row(r);
        end
        // Let every accepted beat leave the DUT
        test_name = "drain";
        out_ready = 1'b1;
        wait_cycles = 0;
        while ((pending_1 != 0 || pending_2 != 0) && wait_cycles < ready_timeout) begin
            @(posedge clock);
            #1;
            wait_cycles++;
        end
        leftover = pending_1 + pending_2;
        if (leftover != 0) begin
            $display("Beats never left the DUT: %0d of channel 1, %0d of channel 2",
                     pending_1, pending_2);
        end
        total = mismatches + unexpected + unstable + timeouts + leftover + reset_errors;
        $write("Errors: %0d mismatch, %0d unexpected, %0d unstable, ",
               mismatches, unexpected, unstable);
        $display("%0d timeout, %0d leftover, %0d reset", timeouts, leftover, reset_errors);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== stream_combiner.f ====
stream_combiner_pkg.sv
stream_framer.sv
stream_arbiter.sv
stream_combiner.sv
tb_stream_checker.sv
tb_stream_combiner.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_stream_combiner
FILELIST  := stream_combiner.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass message shows up as a line of its own
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
